/* tests/tlk_link_tests.txt */
# W addr data err | R addr expect err mask | P count | X | L | F frames, all values hex
# E corrupt count words | I tx_irq rx_irq err_irq enable loopen
# reset values
R 00 0 0 ffffffff
R 04 0 0 ffffffff
R 08 0 0 ffffffff
R 0c 0 0 ffffffff
R 14 0 0 ffffffff
R 18 0 0 ffffffff
R 1c 0 0 ffffffff
I 0 0 0 0 0
# transmit with the tx done interrupt masked
W 18 6 0
P 5
W 04 5 0
W 00 5 0
X
I 0 0 0 1 0
R 14 1 0 7
R 00 4 0 ffffffff
# loopback
W 14 7 0
W 18 7 0
P 8
W 04 8 0
W 00 7 0
X
I 1 1 0 1 1
R 1c 8 0 ffffffff
L
W 14 7 0
W 00 4 0
# external frames, bad checksum then good
E 1 3 1111 2222 3333
I 0 0 1 1 0
L
R 1c 8 0 ffffffff
W 14 4 0
I 0 0 0 1 0
E 0 4 0001 0002 fffe 8000
I 0 1 0 1 0
R 1c 4 0 ffffffff
L
# APB errors
R 20 0 1 0
W 24 1 1
R 10 0 1 0
R 18 7 0 ffffffff
R 0c 0 0 ffffffff
P 20
W 08 1234 1
R 0c 200000 0 ffffffff
W 04 20 0
W 00 5 0
X
# start while busy
P 8
W 04 8 0
W 00 5 0
W 00 5 0
X
F 4
R 0c 0 0 1

/* all.f */
+incdir+hw
hw/tlk_pkg.sv
hw/tlk_fifo.sv
hw/tlk_regs.sv
hw/tlk_tx_framer.sv
hw/tlk_rx_deframer.sv
hw/tlk_link_top.sv
tests/tlk_link_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tlk_link_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tlk_link_tb.sv */
//////////////////////////////////////////////////
// Link controller testbench: clock and reset, APB
// driver, receive pin driver, transmit monitor,
// command file reader and watchdog
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tlk_params.svh"

module tlk_link_tb;

    localparam string TEST_FILE = "tests/tlk_link_tests.txt";

    logic                   clk = 1'b0;
    logic                   i_reset;
    logic                   i_psel;
    logic                   i_penable;
    logic                   i_pwrite;
    logic [`TLK_APB_AW-1:0] i_paddr;
    logic [31:0]            i_pwdata;
    logic [31:0]            o_prdata;
    logic                   o_pready;
    logic                   o_pslverr;
    logic [`TLK_DATA_W-1:0] o_2711_txd;
    logic                   o_2711_tkmsb;
    logic                   o_2711_tklsb;
    logic                   o_2711_enable;
    logic                   o_2711_loopen;
    logic [`TLK_DATA_W-1:0] i_2711_rxd;
    logic                   i_2711_rkmsb;
    logic                   i_2711_rklsb;
    logic                   o_tx_irq;
    logic                   o_rx_irq;
    logic                   o_err_irq;

    // Reference model state
    logic [15:0] tx_model [$];
    logic [15:0] sent [$];
    logic [15:0] mon_body [$];
    logic        in_frame = 1'b0;
    int          frames_seen = 0;
    int          frames_checked = 0;
    int          n_lines = 0;
    int          seed = 32'h5cbd;

    tlk_link_top tlk_link_top_inst (.*);

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("error: %s is %h, expected %h", name, got, want);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // APB driver
    //////////////////////////////////////////////////
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge clk);
        i_penable <= 1'b1;
        // End of the access cycle
        @(posedge clk);
        check_value("o_pready", o_pready, 32'h1);
        rdata = o_prdata;
        err   = o_pslverr;
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic want_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value("o_pslverr", err, want_err);
    endtask

    task automatic apb_read_check(input logic [7:0] addr, input logic [31:0] want,
                                  input logic want_err, input logic [31:0] mask);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        check_value("o_pslverr", err, want_err);
        check_value("o_prdata", rdata & mask, want & mask);
    endtask

    //////////////////////////////////////////////////
    // Transmit side
    //////////////////////////////////////////////////
    task automatic push_payload(input int count);
        logic [15:0] w;
        for (int i = 0; i < count; i++) begin
            w = 16'($random(seed));
            tx_model.push_back(w);
            apb_write(`TLK_REG_TX_DATA, {16'h0, w}, 1'b0);
        end
    endtask

    // Waits for the monitor, then checks length, payload and checksum
    task automatic check_frame();
        logic [15:0] sum;
        int          n;
        int          waited;
        n      = tx_model.size();
        waited = 0;
        while (frames_seen == frames_checked) begin
            @(posedge clk);
            waited++;
            if (waited > 400) begin
                $display("no frame seen on the transmit pins after a start request");
                abort_run();
            end
        end
        frames_checked++;
        check_value("frame word count", mon_body.size(), n + 2);
        check_value("o_2711_txd length word", mon_body[0], n);
        sum = '0;
        for (int i = 0; i < n; i++) begin
            check_value("o_2711_txd payload word", mon_body[i+1], tx_model[i]);
            sum = sum + tx_model[i];
        end
        check_value("o_2711_txd checksum", mon_body[n+1], sum);
        sent = tx_model;
        tx_model.delete();
    endtask

    // Frame collector with idle and K flag checks
    always @(posedge clk) begin
        if (!i_reset) begin
            check_value("o_2711_tkmsb", o_2711_tkmsb, 32'h0);
            if (!in_frame) begin
                check_value("o_2711_tklsb", o_2711_tklsb, 32'h1);
                if (o_2711_txd == `TLK_K_SOF) begin
                    in_frame = 1'b1;
                    mon_body.delete();
                end else begin
                    check_value("o_2711_txd idle", o_2711_txd, `TLK_K_IDLE);
                end
            end else if (o_2711_tklsb) begin
                // Only the end word may carry a K flag inside a frame
                check_value("o_2711_txd end word", o_2711_txd, `TLK_K_EOF);
                in_frame = 1'b0;
                frames_seen++;
            end else begin
                mon_body.push_back(o_2711_txd);
            end
        end
    end

    //////////////////////////////////////////////////
    // Receive side
    //////////////////////////////////////////////////
    task automatic send_rx_frame(input logic corrupt);
        logic [15:0] sum;
        sum = '0;
        @(posedge clk);
        i_2711_rxd   <= `TLK_K_SOF;
        i_2711_rklsb <= 1'b1;
        @(posedge clk);
        i_2711_rxd   <= 16'(sent.size());
        i_2711_rklsb <= 1'b0;
        foreach (sent[i]) begin
            @(posedge clk);
            i_2711_rxd <= sent[i];
            sum = sum + sent[i];
        end
        @(posedge clk);
        i_2711_rxd <= corrupt ? ~sum : sum;
        @(posedge clk);
        i_2711_rxd   <= `TLK_K_EOF;
        i_2711_rklsb <= 1'b1;
        @(posedge clk);
        i_2711_rxd <= `TLK_K_IDLE;
    endtask

    // Last flag only on the final word
    task automatic drain_rx_frame();
        for (int i = 0; i < sent.size(); i++) begin
            apb_read_check(`TLK_REG_RX_DATA, {15'h0, (i == sent.size() - 1), sent[i]},
                           1'b0, 32'h1ffff);
        end
    endtask

    task automatic check_pins(input logic [4:0] want);
        logic [4:0] now;
        now = '0;
        for (int i = 0; i < 50; i++) begin
            @(posedge clk);
            now = {o_tx_irq, o_rx_irq, o_err_irq, o_2711_enable, o_2711_loopen};
            if (now == want) break;
        end
        check_value("o_tx_irq", now[4], want[4]);
        check_value("o_rx_irq", now[3], want[3]);
        check_value("o_err_irq", now[2], want[2]);
        check_value("o_2711_enable", now[1], want[1]);
        check_value("o_2711_loopen", now[0], want[0]);
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    //////////////////////////////////////////////////
    // Watchdog and command loop
    //////////////////////////////////////////////////
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 300) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", n_lines * 300);
        abort_run();
    end

    initial begin
        int          fd;
        int          c;
        int          n;
        logic [7:0]  cmd;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        i_reset      = 1'b1;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        i_2711_rxd   = `TLK_K_IDLE;
        i_2711_rkmsb = 1'b0;
        i_2711_rklsb = 1'b1;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the command file %s", TEST_FILE);
            abort_run();
        end
        // Line count sets the watchdog limit
        n = 1;
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == 10) n++;
            c = $fgetc(fd);
        end
        $fclose(fd);
        n_lines = n;
        fd = $fopen(TEST_FILE, "r");
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;
        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": skip_line(fd);
                "W": begin
                    n = $fscanf(fd, "%h %h %h", a0, a1, a2);
                    apb_write(a0[7:0], a1, a2[0]);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
                    apb_read_check(a0[7:0], a1, a2[0], a3);
                end
                "P": begin
                    n = $fscanf(fd, "%h", a0);
                    push_payload(a0);
                end
                "X": check_frame();
                "E": begin
                    n = $fscanf(fd, "%h %h", a0, a1);
                    sent.delete();
                    for (int i = 0; i < a1; i++) begin
                        n = $fscanf(fd, "%h", a2);
                        sent.push_back(a2[15:0]);
                    end
                    send_rx_frame(a0[0]);
                end
                "L": drain_rx_frame();
                "I": begin
                    n = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
                    check_pins({a0[0], a1[0], a2[0], a3[0], a4[0]});
                end
                "F": begin
                    n = $fscanf(fd, "%h", a0);
                    repeat (100) @(posedge clk);
                    check_value("frames seen on o_2711_txd", frames_seen, a0);
                end
                default: begin
                    $display("unknown command %c in the command file", cmd);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* hw/tlk_link_top.sv */
//////////////////////////////////////////////////
// Link controller top: registers, buffers,
// framer and deframer
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tlk_params.svh"

module tlk_link_top (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [`TLK_APB_AW-1:0] i_paddr,
    input  logic [31:0]            i_pwdata,
    output logic [31:0]            o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    output logic [`TLK_DATA_W-1:0] o_2711_txd,
    output logic                   o_2711_tkmsb,
    output logic                   o_2711_tklsb,
    output logic                   o_2711_enable,
    output logic                   o_2711_loopen,
    input  logic [`TLK_DATA_W-1:0] i_2711_rxd,
    input  logic                   i_2711_rkmsb,
    input  logic                   i_2711_rklsb,
    output logic                   o_tx_irq,
    output logic                   o_rx_irq,
    output logic                   o_err_irq
);

    localparam int LW = $clog2(`TLK_FIFO_DEPTH) + 1;

    logic                   tx_push, tx_pop, tx_start, tx_busy, tx_done;
    logic [`TLK_DATA_W-1:0] tx_push_data, tx_head;
    logic [LW-1:0]          tx_level, tx_len;
    logic                   rx_push, rx_pop, rx_full, rx_empty;
    logic                   rx_frame, rx_error, loopback;
    tlk_pkg::rx_entry_t     rx_push_data, rx_head;
    logic [LW-1:0]          rx_level, rx_frame_len;

    tlk_regs tlk_regs_inst (
        .clk(clk), .i_reset(i_reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_tx_push(tx_push), .o_tx_push_data(tx_push_data), .i_tx_level(tx_level),
        .o_tx_start(tx_start), .o_tx_len(tx_len),
        .i_tx_busy(tx_busy), .i_tx_done(tx_done),
        .o_rx_pop(rx_pop), .i_rx_head(rx_head), .i_rx_level(rx_level),
        .i_rx_empty(rx_empty), .i_rx_frame(rx_frame), .i_rx_error(rx_error),
        .i_rx_frame_len(rx_frame_len), .o_loopback(loopback),
        .o_2711_enable(o_2711_enable), .o_2711_loopen(o_2711_loopen),
        .o_tx_irq(o_tx_irq), .o_rx_irq(o_rx_irq), .o_err_irq(o_err_irq)
    );

    tlk_fifo #(.payload_t(logic [`TLK_DATA_W-1:0])) tx_fifo (
        .clk(clk), .i_reset(i_reset),
        .i_push(tx_push), .i_push_data(tx_push_data), .i_pop(tx_pop),
        .o_head(tx_head), .o_level(tx_level), .o_full(), .o_empty()
    );

    tlk_fifo #(.payload_t(tlk_pkg::rx_entry_t)) rx_fifo (
        .clk(clk), .i_reset(i_reset),
        .i_push(rx_push), .i_push_data(rx_push_data), .i_pop(rx_pop),
        .o_head(rx_head), .o_level(rx_level), .o_full(rx_full), .o_empty(rx_empty)
    );

    tlk_tx_framer tlk_tx_framer_inst (
        .clk(clk), .i_reset(i_reset),
        .i_start(tx_start), .i_len(tx_len), .i_head(tx_head), .i_level(tx_level),
        .o_pop(tx_pop), .o_busy(tx_busy), .o_done(tx_done),
        .o_2711_txd(o_2711_txd), .o_2711_tkmsb(o_2711_tkmsb), .o_2711_tklsb(o_2711_tklsb)
    );

    // Loopback taps the transmit pins
    tlk_rx_deframer tlk_rx_deframer_inst (
        .clk(clk), .i_reset(i_reset), .i_loopback(loopback),
        .i_tx_txd(o_2711_txd), .i_tx_tklsb(o_2711_tklsb),
        .i_2711_rxd(i_2711_rxd), .i_2711_rkmsb(i_2711_rkmsb), .i_2711_rklsb(i_2711_rklsb),
        .i_full(rx_full), .o_push(rx_push), .o_push_data(rx_push_data),
        .o_frame(rx_frame), .o_error(rx_error), .o_frame_len(rx_frame_len)
    );

endmodule

/* hw/tlk_rx_deframer.sv */
//////////////////////////////////////////////////
// Receive deframer: source select, length and
// checksum check, payload push
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tlk_params.svh"

module tlk_rx_deframer #(
    parameter int LW = $clog2(`TLK_FIFO_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_loopback,
    input  logic [`TLK_DATA_W-1:0] i_tx_txd,
    input  logic                   i_tx_tklsb,
    input  logic [`TLK_DATA_W-1:0] i_2711_rxd,
    input  logic                   i_2711_rkmsb,
    input  logic                   i_2711_rklsb,
    input  logic                   i_full,
    output logic                   o_push,
    output tlk_pkg::rx_entry_t     o_push_data,
    output logic                   o_frame,
    output logic                   o_error,
    output logic [LW-1:0]          o_frame_len
);

    typedef enum logic [2:0] {S_HUNT, S_LEN, S_DATA, S_CSUM, S_EOF} state_t;

    state_t                 state;
    logic [`TLK_DATA_W-1:0] in_d;
    logic                   in_k;
    logic [`TLK_DATA_W-1:0] sum;
    logic [LW-1:0]          len_q;
    logic [LW-1:0]          cnt;
    logic                   csum_ok;
    logic                   dropped;
    logic                   good;

    // Input stage registers the selected source
    always_ff @(posedge clk) begin
        in_d <= i_loopback ? i_tx_txd : i_2711_rxd;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            in_k <= 1'b0;
        end else begin
            in_k <= i_loopback ? i_tx_tklsb : (i_2711_rkmsb | i_2711_rklsb);
        end
    end

    assign good = in_k && (in_d == `TLK_K_EOF) && csum_ok && !dropped;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state   <= S_HUNT;
            o_push  <= 1'b0;
            o_frame <= 1'b0;
            o_error <= 1'b0;
            dropped <= 1'b0;
        end else begin
            o_push  <= 1'b0;
            o_frame <= 1'b0;
            o_error <= 1'b0;
            // Full buffer loses the word since the link has no back-pressure
            if (o_push && i_full) begin
                dropped <= 1'b1;
            end
            case (state)
                S_HUNT: if (in_k && in_d == `TLK_K_SOF) state <= S_LEN;
                S_LEN: begin
                    dropped <= 1'b0;
                    if (in_k || in_d == '0 || in_d > `TLK_FIFO_DEPTH) begin
                        o_error <= 1'b1;
                        state   <= S_HUNT;
                    end else begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (in_k) begin
                        o_error <= 1'b1;
                        state   <= S_HUNT;
                    end else begin
                        o_push <= 1'b1;
                        if (cnt == 1) state <= S_CSUM;
                    end
                end
                S_CSUM: state <= S_EOF;
                default: begin
                    o_frame <= good;
                    o_error <= !good;
                    state   <= S_HUNT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_LEN: begin
                len_q <= in_d[LW-1:0];
                cnt   <= in_d[LW-1:0];
                sum   <= '0;
            end
            S_DATA: begin
                o_push_data.word <= in_d;
                o_push_data.last <= (cnt == 1);
                sum              <= sum + in_d;
                cnt              <= cnt - 1'b1;
            end
            S_CSUM: csum_ok <= !in_k && (in_d == sum);
            S_EOF:  o_frame_len <= len_q;
            default: ;
        endcase
    end

endmodule

/* hw/tlk_tx_framer.sv */
//////////////////////////////////////////////////
// Transmit framer: idle fill, then start, length,
// payload, checksum and end words
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tlk_params.svh"

module tlk_tx_framer #(
    parameter int LW = $clog2(`TLK_FIFO_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [LW-1:0]          i_len,
    input  logic [`TLK_DATA_W-1:0] i_head,
    input  logic [LW-1:0]          i_level,
    output logic                   o_pop,
    output logic                   o_busy,
    output logic                   o_done,
    output logic [`TLK_DATA_W-1:0] o_2711_txd,
    output logic                   o_2711_tkmsb,
    output logic                   o_2711_tklsb
);

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT, S_SOF, S_LEN, S_DATA, S_CSUM, S_EOF
    } state_t;

    state_t                 state;
    logic [LW-1:0]          len_q;
    logic [LW-1:0]          cnt;
    logic [`TLK_DATA_W-1:0] sum;

    assign o_pop  = (state == S_DATA);
    assign o_busy = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (i_start) state <= S_WAIT;
                // Hold off until the whole payload is buffered
                S_WAIT:  if (i_level >= len_q) state <= S_SOF;
                S_SOF:   state <= S_LEN;
                S_LEN:   state <= (len_q == '0) ? S_CSUM : S_DATA;
                S_DATA:  if (cnt == 1) state <= S_CSUM;
                S_CSUM:  state <= S_EOF;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: if (i_start) len_q <= i_len;
            S_SOF: begin
                cnt <= len_q;
                sum <= '0;
            end
            S_DATA: begin
                cnt <= cnt - 1'b1;
                sum <= sum + i_head;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////
    // Transceiver pins
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_2711_txd   <= `TLK_K_IDLE;
            o_2711_tklsb <= 1'b1;
            o_done       <= 1'b0;
        end else begin
            o_done       <= (state == S_EOF);
            o_2711_tklsb <= 1'b0;
            case (state)
                S_SOF:  o_2711_txd <= `TLK_K_SOF;
                S_LEN:  o_2711_txd <= {{(`TLK_DATA_W-LW){1'b0}}, len_q};
                S_DATA: o_2711_txd <= i_head;
                S_CSUM: o_2711_txd <= sum;
                S_EOF:  o_2711_txd <= `TLK_K_EOF;
                default: o_2711_txd <= `TLK_K_IDLE;
            endcase
            if (state inside {S_IDLE, S_WAIT, S_SOF, S_EOF}) begin
                o_2711_tklsb <= 1'b1;
            end
        end
    end

    // High byte never carries a K character
    assign o_2711_tkmsb = 1'b0;

endmodule

/* hw/tlk_regs.sv */
//////////////////////////////////////////////////
// APB register block: control, buffer ports,
// status, sticky interrupts
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tlk_params.svh"

module tlk_regs #(
    parameter int LW = $clog2(`TLK_FIFO_DEPTH) + 1
) (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [`TLK_APB_AW-1:0] i_paddr,
    input  logic [31:0]            i_pwdata,
    output logic [31:0]            o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    output logic                   o_tx_push,
    output logic [`TLK_DATA_W-1:0] o_tx_push_data,
    input  logic [LW-1:0]          i_tx_level,
    output logic                   o_tx_start,
    output logic [LW-1:0]          o_tx_len,
    input  logic                   i_tx_busy,
    input  logic                   i_tx_done,
    output logic                   o_rx_pop,
    input  tlk_pkg::rx_entry_t     i_rx_head,
    input  logic [LW-1:0]          i_rx_level,
    input  logic                   i_rx_empty,
    input  logic                   i_rx_frame,
    input  logic                   i_rx_error,
    input  logic [LW-1:0]          i_rx_frame_len,
    output logic                   o_loopback,
    output logic                   o_2711_enable,
    output logic                   o_2711_loopen,
    output logic                   o_tx_irq,
    output logic                   o_rx_irq,
    output logic                   o_err_irq
);

    logic          access;
    logic          addr_ok;
    logic          tx_full;
    logic          bad;
    logic          wr_en;
    logic          rd_en;
    logic [2:0]    irq_set;
    logic [2:0]    irq_stat;
    logic [2:0]    irq_en;
    logic [LW-1:0] rx_len_q;

    //////////////////////////////////////////////////
    // Access decode
    //////////////////////////////////////////////////
    assign o_pready = 1'b1;
    assign access   = i_psel && i_penable;
    assign tx_full  = (i_tx_level == `TLK_FIFO_DEPTH);

    assign bad = !addr_ok
        || (i_paddr == `TLK_REG_RX_DATA && !i_pwrite && i_rx_empty)
        || (i_paddr == `TLK_REG_TX_DATA && i_pwrite && tx_full);

    assign o_pslverr = access && bad;
    assign wr_en     = access && i_pwrite && !bad;
    assign rd_en     = access && !i_pwrite && !bad;

    assign o_tx_push      = wr_en && (i_paddr == `TLK_REG_TX_DATA);
    assign o_tx_push_data = i_pwdata[`TLK_DATA_W-1:0];
    assign o_rx_pop       = rd_en && (i_paddr == `TLK_REG_RX_DATA);

    // Read mux that also flags mapped addresses
    always_comb begin
        o_prdata = '0;
        addr_ok  = 1'b1;
        case (i_paddr)
            `TLK_REG_CTRL:     o_prdata[2:1] = {o_2711_enable, o_loopback};
            `TLK_REG_TX_LEN:   o_prdata[LW-1:0] = o_tx_len;
            `TLK_REG_TX_DATA:  o_prdata = '0;
            `TLK_REG_STATUS: begin
                o_prdata[0]       = i_tx_busy;
                o_prdata[8 +: LW]  = i_rx_level;
                o_prdata[16 +: LW] = i_tx_level;
            end
            `TLK_REG_RX_DATA:  o_prdata[16:0] = i_rx_head;
            `TLK_REG_IRQ_STAT: o_prdata[2:0] = irq_stat;
            `TLK_REG_IRQ_EN:   o_prdata[2:0] = irq_en;
            `TLK_REG_RX_LEN:   o_prdata[LW-1:0] = rx_len_q;
            default:           addr_ok = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////
    always_comb begin
        irq_set = '0;
        irq_set[tlk_pkg::IRQ_TX_DONE]  = i_tx_done;
        irq_set[tlk_pkg::IRQ_RX_FRAME] = i_rx_frame;
        irq_set[tlk_pkg::IRQ_RX_ERR]   = i_rx_error;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_tx_start    <= 1'b0;
            o_loopback    <= 1'b0;
            o_2711_enable <= 1'b0;
            o_tx_len      <= '0;
            irq_en        <= '0;
            irq_stat      <= '0;
            rx_len_q      <= '0;
        end else begin
            // Start bit is a one-cycle pulse
            o_tx_start <= wr_en && (i_paddr == `TLK_REG_CTRL) && i_pwdata[0];
            if (wr_en && i_paddr == `TLK_REG_CTRL) begin
                o_loopback    <= i_pwdata[1];
                o_2711_enable <= i_pwdata[2];
            end
            if (wr_en && i_paddr == `TLK_REG_TX_LEN) begin
                o_tx_len <= i_pwdata[LW-1:0];
            end
            if (wr_en && i_paddr == `TLK_REG_IRQ_EN) begin
                irq_en <= i_pwdata[2:0];
            end
            // New events win over a clear in the same cycle
            if (wr_en && i_paddr == `TLK_REG_IRQ_STAT) begin
                irq_stat <= (irq_stat & ~i_pwdata[2:0]) | irq_set;
            end else begin
                irq_stat <= irq_stat | irq_set;
            end
            if (i_rx_frame) begin
                rx_len_q <= i_rx_frame_len;
            end
        end
    end

    assign o_2711_loopen = o_loopback;
    assign o_tx_irq  = irq_stat[tlk_pkg::IRQ_TX_DONE] & irq_en[tlk_pkg::IRQ_TX_DONE];
    assign o_rx_irq  = irq_stat[tlk_pkg::IRQ_RX_FRAME] & irq_en[tlk_pkg::IRQ_RX_FRAME];
    assign o_err_irq = irq_stat[tlk_pkg::IRQ_RX_ERR] & irq_en[tlk_pkg::IRQ_RX_ERR];

endmodule

/* hw/tlk_fifo.sv */
//////////////////////////////////////////////////
// Show-ahead synchronous FIFO, payload type set
// by parameter
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "tlk_params.svh"

module tlk_fifo #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = `TLK_FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_push,
    input  payload_t               i_push_data,
    input  logic                   i_pop,
    output payload_t               o_head,
    output logic [$clog2(DEPTH):0] o_level,
    output logic                   o_full,
    output logic                   o_empty
);

    localparam int AW = $clog2(DEPTH);

    payload_t          mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic              do_push;
    logic              do_pop;

    // Overflow and underflow requests are ignored
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_level <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                o_level <= o_level + 1'b1;
            end else if (do_pop && !do_push) begin
                o_level <= o_level - 1'b1;
            end
        end
    end

    assign o_head  = mem[rd_ptr];
    assign o_full  = (o_level == DEPTH);
    assign o_empty = (o_level == '0);

endmodule

/* hw/tlk_pkg.sv */
//////////////////////////////////////////////////
// Receive buffer entry type and interrupt bit
// positions
//////////////////////////////////////////////////
`include "tlk_params.svh"

package tlk_pkg;

    // Last flag lands in bit 16 of RX_DATA
    typedef struct packed {
        logic                   last;
        logic [`TLK_DATA_W-1:0] word;
    } rx_entry_t;

    // Bit positions in IRQ_STAT and IRQ_EN
    typedef enum int {
        IRQ_TX_DONE  = 0,
        IRQ_RX_FRAME = 1,
        IRQ_RX_ERR   = 2
    } irq_bit_e;

endpackage

/* hw/tlk_params.svh */
//////////////////////////////////////////////////
// Link word width, APB address width, buffer depth,
// K words and register byte addresses
//////////////////////////////////////////////////
`ifndef TLK_PARAMS_SVH
`define TLK_PARAMS_SVH

`define TLK_DATA_W       16
`define TLK_APB_AW       8
// Power of two
`define TLK_FIFO_DEPTH   32

// K words, low-byte K flag set
`define TLK_K_IDLE       16'hC5BC
`define TLK_K_SOF        16'hFB5C
`define TLK_K_EOF        16'hFD5C

`define TLK_REG_CTRL     8'h00
`define TLK_REG_TX_LEN   8'h04
`define TLK_REG_TX_DATA  8'h08
`define TLK_REG_STATUS   8'h0C
`define TLK_REG_RX_DATA  8'h10
`define TLK_REG_IRQ_STAT 8'h14
`define TLK_REG_IRQ_EN   8'h18
`define TLK_REG_RX_LEN   8'h1C

`endif
